/* sources.f */
+incdir+test
common/isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
rtl/hazard_unit.sv
rtl/core_datapath.sv
test/tb_core_datapath.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_core_datapath

out=$(./obj_dir/Vtb_core_datapath)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

/* test/tb_programs.svh */
/*
 * Program and retirement tables for the core testbench.
 * Each row is a program of PROG_LEN words, padded with a JAL x0,0 self
 * loop, and the register writes it must retire, in order.
 * Needs isa_pkg imported and a seed variable declared before the include.
 */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS = 6;
localparam int PROG_LEN  = 16;
localparam int MAX_RET   = 8;

// JAL x0, 0 parks the core without retiring anything.
localparam instr_t HALT_WORD = {25'd0, OP_JAL};

string     test_name [NUM_TESTS];
instr_t    prog      [NUM_TESTS][PROG_LEN];
int        prog_fill [NUM_TESTS];
reg_addr_t ret_rd    [NUM_TESTS][MAX_RET];
data_t     ret_val   [NUM_TESTS][MAX_RET];
int        ret_count [NUM_TESTS];

// ------------------------------
// Instruction encoders.
// ------------------------------
function automatic instr_t rtype_word(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                      reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic instr_t itype_word(logic [6:0] op, logic [2:0] f3, reg_addr_t rd,
                                      reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

// SD rs2, imm(rs1).
function automatic instr_t stype_word(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_DW, imm[4:0], OP_STORE};
endfunction

function automatic instr_t btype_word(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                      logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic instr_t jtype_word(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

function automatic data_t sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
endfunction

task automatic append_word(input int t, input instr_t w);
    prog[t][prog_fill[t]] = w;
    prog_fill[t]++;
endtask

task automatic push_retire(input int t, input reg_addr_t rd, input data_t v);
    ret_rd[t][ret_count[t]]  = rd;
    ret_val[t][ret_count[t]] = v;
    ret_count[t]++;
endtask

// ------------------------------
// Table contents.
// ------------------------------
task automatic build_tables();
    int          t;
    int          i;
    int          rnd;
    logic [11:0] r1;
    logic [11:0] r2;
    logic [11:0] r3;
    data_t       v1;
    data_t       v2;
    data_t       v3;
    data_t       v4;
    data_t       v5;
    data_t       v6;
    data_t       v7;
    data_t       v8;
    data_t       vs;

    for (t = 0; t < NUM_TESTS; t++) begin
        prog_fill[t] = 0;
        ret_count[t] = 0;
        for (i = 0; i < PROG_LEN; i++) begin
            prog[t][i] = HALT_WORD;
        end
    end

    rnd = $random(seed);
    r1  = rnd[11:0];
    rnd = $random(seed);
    r2  = rnd[11:0];
    rnd = $random(seed);
    r3  = rnd[11:0];

    // Dependent chain, every operand comes from a recent result.
    v1 = sext12(r1);
    v2 = v1 + sext12(r2);
    v3 = v2 + v1;
    v4 = v1 - v3;
    v5 = v4 & v2;
    v6 = v5 | v3;
    v7 = v6 ^ v4;
    v8 = ($signed(v7) < $signed(v1)) ? 64'd1 : 64'd0;
    test_name[0] = "alu_chain";
    append_word(0, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, r1));
    append_word(0, itype_word(OP_IMM, F3_ADD_SUB, 5'd2, 5'd1, r2));
    append_word(0, rtype_word(F7_BASE, F3_ADD_SUB, 5'd3, 5'd2, 5'd1));
    append_word(0, rtype_word(F7_SUB, F3_ADD_SUB, 5'd4, 5'd1, 5'd3));
    append_word(0, rtype_word(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd2));
    append_word(0, rtype_word(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd3));
    append_word(0, rtype_word(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4));
    append_word(0, rtype_word(F7_BASE, F3_SLT, 5'd8, 5'd7, 5'd1));
    push_retire(0, 5'd1, v1);
    push_retire(0, 5'd2, v2);
    push_retire(0, 5'd3, v3);
    push_retire(0, 5'd4, v4);
    push_retire(0, 5'd5, v5);
    push_retire(0, 5'd6, v6);
    push_retire(0, 5'd7, v7);
    push_retire(0, 5'd8, v8);

    // Store, load back, then use the load at once.
    vs = sext12(r3);
    test_name[1] = "store_load";
    append_word(1, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, r3));
    append_word(1, itype_word(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd40));
    append_word(1, stype_word(5'd1, 5'd2, 12'd8));
    append_word(1, itype_word(OP_LOAD, F3_DW, 5'd3, 5'd2, 12'd8));
    append_word(1, rtype_word(F7_BASE, F3_ADD_SUB, 5'd4, 5'd3, 5'd1));
    push_retire(1, 5'd1, vs);
    push_retire(1, 5'd2, 64'd40);
    push_retire(1, 5'd3, vs);
    push_retire(1, 5'd4, vs + vs);

    // BEQ at pc 8 jumps to pc 20 over x3 and x4.
    test_name[2] = "beq_taken";
    append_word(2, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd3));
    append_word(2, itype_word(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd3));
    append_word(2, btype_word(F3_BEQ, 5'd1, 5'd2, 13'd12));
    append_word(2, itype_word(OP_IMM, F3_ADD_SUB, 5'd3, 5'd0, 12'd9));
    append_word(2, itype_word(OP_IMM, F3_ADD_SUB, 5'd4, 5'd0, 12'd9));
    append_word(2, itype_word(OP_IMM, F3_ADD_SUB, 5'd5, 5'd1, 12'd4));
    push_retire(2, 5'd1, 64'd3);
    push_retire(2, 5'd2, 64'd3);
    push_retire(2, 5'd5, 64'd7);

    test_name[3] = "bne_not_taken";
    append_word(3, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd7));
    append_word(3, itype_word(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd7));
    append_word(3, btype_word(F3_BNE, 5'd1, 5'd2, 13'd12));
    append_word(3, itype_word(OP_IMM, F3_ADD_SUB, 5'd3, 5'd0, 12'd1));
    append_word(3, itype_word(OP_IMM, F3_ADD_SUB, 5'd4, 5'd3, 12'd1));
    push_retire(3, 5'd1, 64'd7);
    push_retire(3, 5'd2, 64'd7);
    push_retire(3, 5'd3, 64'd1);
    push_retire(3, 5'd4, 64'd2);

    // JAL at pc 4 links 8 and lands on pc 16.
    test_name[4] = "jal_link";
    append_word(4, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd5));
    append_word(4, jtype_word(5'd2, 21'd12));
    append_word(4, itype_word(OP_IMM, F3_ADD_SUB, 5'd3, 5'd0, 12'd1));
    append_word(4, itype_word(OP_IMM, F3_ADD_SUB, 5'd4, 5'd0, 12'd2));
    append_word(4, rtype_word(F7_BASE, F3_ADD_SUB, 5'd5, 5'd2, 5'd1));
    push_retire(4, 5'd1, 64'd5);
    push_retire(4, 5'd2, 64'd8);
    push_retire(4, 5'd5, 64'd13);

    // Writes to x0 must vanish, x0 keeps reading zero.
    test_name[5] = "x0_writes";
    append_word(5, itype_word(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd5));
    append_word(5, itype_word(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd9));
    append_word(5, rtype_word(F7_BASE, F3_ADD_SUB, 5'd0, 5'd1, 5'd1));
    append_word(5, rtype_word(F7_BASE, F3_ADD_SUB, 5'd2, 5'd0, 5'd1));
    append_word(5, jtype_word(5'd0, 21'd8));
    append_word(5, itype_word(OP_IMM, F3_ADD_SUB, 5'd3, 5'd0, 12'd1));
    append_word(5, itype_word(OP_IMM, F3_ADD_SUB, 5'd4, 5'd2, 12'd1));
    push_retire(5, 5'd1, 64'd9);
    push_retire(5, 5'd2, 64'd9);
    push_retire(5, 5'd4, 64'd10);
endtask

`endif

/* test/tb_core_datapath.sv */
/*
 * Testbench for the pipelined core. Runs each table row as its own
 * program and checks the write-back port, in order, against the
 * expected register writes. Any write-back outside the list is an error.
 */
`timescale 1ns/1ps

module tb_core_datapath;

    import isa_pkg::*;

    localparam int TIMEOUT = 200;

    logic      i_clk = 1'b0;
    logic      i_arst;
    logic      run_i;
    logic      imem_we_i;
    data_t     imem_addr_i;
    instr_t    imem_data_i;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    data_t     wb_data_o;

    int seed         = 63;
    int mismatches   = 0;
    int timeouts     = 0;
    int other_errors = 0;

    `include "tb_programs.svh"

    core_datapath #(
        .IMEM_DEPTH ( 64 ),
        .DMEM_DEPTH ( 64 )
    ) UUT (
        .i_clk       ( i_clk       ),
        .i_arst      ( i_arst      ),
        .run_i       ( run_i       ),
        .imem_we_i   ( imem_we_i   ),
        .imem_addr_i ( imem_addr_i ),
        .imem_data_i ( imem_data_i ),
        .wb_we_o     ( wb_we_o     ),
        .wb_rd_o     ( wb_rd_o     ),
        .wb_data_o   ( wb_data_o   )
    );

    // 100 ns period.
    always #50 i_clk = ~i_clk;

    // ------------------------------
    // Helpers.
    // ------------------------------
    task automatic load_program(input int t);
        int i;
        for (i = 0; i < PROG_LEN; i++) begin
            @(posedge i_clk);
            imem_we_i   <= 1'b1;
            imem_addr_i <= data_t'(i);
            imem_data_i <= prog[t][i];
        end
        @(posedge i_clk);
        imem_we_i <= 1'b0;
    endtask

    // Waits for the next write-back pulse and compares it.
    task automatic expect_retire(input string name, input reg_addr_t rd, input data_t val,
                                 output logic seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT) begin
            @(negedge i_clk);
            waited++;
            if (wb_we_o) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout in %s: no register write within %0d cycles, x%0d was expected",
                     name, TIMEOUT, rd);
        end else begin
            if (wb_rd_o !== rd) begin
                mismatches++;
                $display("Mismatch in %s: destination expected x%0d, actual x%0d",
                         name, rd, wb_rd_o);
            end
            if (wb_data_o !== val) begin
                mismatches++;
                $display("Mismatch in %s: x%0d expected 0x%016h, actual 0x%016h",
                         name, rd, val, wb_data_o);
            end
        end
    endtask

    // No write-back may show up in this window.
    task automatic check_quiet(input string name, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge i_clk);
            if (wb_we_o) begin
                other_errors++;
                $display("Unexpected register write during %s: x%0d = 0x%016h",
                         name, wb_rd_o, wb_data_o);
            end
        end
    endtask

    // ------------------------------
    // Main sequence.
    // ------------------------------
    initial begin
        int   t;
        int   k;
        int   total;
        logic seen;

        i_arst      <= 1'b1;
        run_i       <= 1'b0;
        imem_we_i   <= 1'b0;
        imem_addr_i <= '0;
        imem_data_i <= '0;
        build_tables();

        repeat (4) @(posedge i_clk);
        i_arst <= 1'b0;
        check_quiet("idle after reset", 8);

        for (t = 0; t < NUM_TESTS; t++) begin
            load_program(t);
            @(posedge i_clk);
            run_i <= 1'b1;
            seen = 1'b1;
            for (k = 0; k < ret_count[t] && seen; k++) begin
                expect_retire(test_name[t], ret_rd[t][k], ret_val[t][k], seen);
            end
            // Program is parked in its halt loop now.
            if (seen) begin
                check_quiet(test_name[t], 12);
            end
            @(posedge i_clk);
            run_i <= 1'b0;
            if (seen) begin
                check_quiet("idle between programs", 6);
            end
        end

        total = mismatches + timeouts + other_errors;
        $display("Errors: %0d (mismatches %0d, timeouts %0d, other %0d)",
                 total, mismatches, timeouts, other_errors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* rtl/core_datapath.sv */
/*
 * Five-stage RV64I subset core with its own hazard unit.
 * Load the program while run_i is low; the PC starts at 0.
 * Branches are predicted not taken and cost two cycles when taken.
 * One write-back pulse per register write, never for x0.
 */
`timescale 1ns/1ps

module core_datapath #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic              i_clk,
    input  logic              i_arst,
    input  logic              run_i,
    input  logic              imem_we_i,
    input  isa_pkg::data_t    imem_addr_i,
    input  isa_pkg::instr_t   imem_data_i,
    output logic              wb_we_o,
    output isa_pkg::reg_addr_t wb_rd_o,
    output isa_pkg::data_t    wb_data_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // ------------------------------
    // Stage-to-stage nets.
    // ------------------------------
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    data_t     mem_fwd;
    data_t     target;
    logic      redirect;

    // Hazard control.
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    logic      stall;
    logic      flush_dec;
    logic      flush_exec;
    fwd_sel_t  fwd_rs1;
    fwd_sel_t  fwd_rs2;

    fetch_stage #(
        .IMEM_DEPTH ( IMEM_DEPTH )
    ) u_fetch (
        .i_clk       ( i_clk       ),
        .i_arst      ( i_arst      ),
        .run_i       ( run_i       ),
        .imem_we_i   ( imem_we_i   ),
        .imem_addr_i ( imem_addr_i ),
        .imem_data_i ( imem_data_i ),
        .stall_i     ( stall       ),
        .flush_i     ( flush_dec   ),
        .redirect_i  ( redirect    ),
        .target_i    ( target      ),
        .if_id_o     ( if_id       )
    );

    decode_stage u_decode (
        .i_clk      ( i_clk      ),
        .i_arst     ( i_arst     ),
        .if_id_i    ( if_id      ),
        .wb_i       ( wb         ),
        .stall_i    ( stall      ),
        .flush_i    ( flush_exec ),
        .rs1_addr_o ( dec_rs1    ),
        .rs2_addr_o ( dec_rs2    ),
        .id_ex_o    ( id_ex      )
    );

    execute_stage u_execute (
        .i_clk      ( i_clk    ),
        .i_arst     ( i_arst   ),
        .id_ex_i    ( id_ex    ),
        .fwd_rs1_i  ( fwd_rs1  ),
        .fwd_rs2_i  ( fwd_rs2  ),
        .mem_fwd_i  ( mem_fwd  ),
        .wb_i       ( wb       ),
        .redirect_o ( redirect ),
        .target_o   ( target   ),
        .ex_mem_o   ( ex_mem   )
    );

    memory_stage #(
        .DMEM_DEPTH ( DMEM_DEPTH )
    ) u_memory (
        .i_clk     ( i_clk   ),
        .i_arst    ( i_arst  ),
        .ex_mem_i  ( ex_mem  ),
        .mem_fwd_o ( mem_fwd ),
        .wb_o      ( wb      )
    );

    hazard_unit u_hazard (
        .i_clk        ( i_clk      ),
        .i_arst       ( i_arst     ),
        .dec_rs1_i    ( dec_rs1    ),
        .dec_rs2_i    ( dec_rs2    ),
        .id_ex_i      ( id_ex      ),
        .ex_mem_i     ( ex_mem     ),
        .wb_i         ( wb         ),
        .redirect_i   ( redirect   ),
        .stall_o      ( stall      ),
        .flush_dec_o  ( flush_dec  ),
        .flush_exec_o ( flush_exec ),
        .fwd_rs1_o    ( fwd_rs1    ),
        .fwd_rs2_o    ( fwd_rs2    )
    );

    // Retirement port.
    assign wb_we_o   = wb.reg_we;
    assign wb_rd_o   = wb.rd;
    assign wb_data_o = wb.data;

endmodule

/* rtl/hazard_unit.sv */
/*
 * Forwarding select, load-use stall and redirect flushes.
 * All outputs are combinational levels for the current cycle.
 * The clock and reset only serve the checks.
 */
`timescale 1ns/1ps

module hazard_unit (
    input  logic               i_clk,
    input  logic               i_arst,
    input  isa_pkg::reg_addr_t dec_rs1_i,
    input  isa_pkg::reg_addr_t dec_rs2_i,
    input  pipe_pkg::id_ex_t   id_ex_i,
    input  pipe_pkg::ex_mem_t  ex_mem_i,
    input  pipe_pkg::wb_t      wb_i,
    input  logic               redirect_i,
    output logic               stall_o,
    output logic               flush_dec_o,
    output logic               flush_exec_o,
    output pipe_pkg::fwd_sel_t fwd_rs1_o,
    output pipe_pkg::fwd_sel_t fwd_rs2_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // Youngest producer wins.
    function automatic fwd_sel_t pick(reg_addr_t rs);
        if (ex_mem_i.reg_we && ex_mem_i.rd != '0 && ex_mem_i.rd == rs) begin
            return FWD_MEM;
        end else if (wb_i.reg_we && wb_i.rd != '0 && wb_i.rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_rs1_o = pick(id_ex_i.rs1_addr);
    assign fwd_rs2_o = pick(id_ex_i.rs2_addr);

    // Load in execute feeding the word in decode.
    assign stall_o = id_ex_i.mem_read && id_ex_i.rd != '0 &&
                     (id_ex_i.rd == dec_rs1_i || id_ex_i.rd == dec_rs2_i);

    assign flush_dec_o  = redirect_i;
    assign flush_exec_o = redirect_i || stall_o;

    a_no_stall_on_redirect : assert property (@(posedge i_clk) disable iff (i_arst)
        !(stall_o && flush_dec_o));

endmodule

/* memory/memory_stage.sv */
/*
 * Doubleword data RAM with a combinational read. Only aligned
 * doubleword accesses exist; address bits 2:0 are ignored.
 * The RAM is not cleared by reset.
 */
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic              i_clk,
    input  logic              i_arst,
    input  pipe_pkg::ex_mem_t ex_mem_i,
    output isa_pkg::data_t    mem_fwd_o,
    output pipe_pkg::wb_t     wb_o
);

    import isa_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    data_t            ram [DMEM_DEPTH];
    logic [IDX_W-1:0] idx;
    data_t            load_data;

    assign idx       = ex_mem_i.alu_res[3 +: IDX_W];
    assign load_data = ram[idx];
    assign mem_fwd_o = ex_mem_i.link;

    always_ff @(posedge i_clk) begin
        if (ex_mem_i.mem_we) begin
            ram[idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            wb_o <= '0;
        end else begin
            wb_o.reg_we <= ex_mem_i.reg_we;
            wb_o.rd     <= ex_mem_i.rd;
            wb_o.data   <= ex_mem_i.mem_read ? load_data : ex_mem_i.link;
        end
    end

    a_dmem_range : assert property (@(posedge i_clk) disable iff (i_arst)
        (ex_mem_i.mem_we || ex_mem_i.mem_read) |->
            ex_mem_i.alu_res < data_t'(DMEM_DEPTH * 8));

endmodule

/* execute/execute_stage.sv */
/*
 * Operand forwarding, ALU and branch resolution.
 * Redirect is combinational and taken in the same cycle by fetch.
 * SLT compares signed; branch targets are pc + immediate.
 */
`timescale 1ns/1ps

module execute_stage (
    input  logic               i_clk,
    input  logic               i_arst,
    input  pipe_pkg::id_ex_t   id_ex_i,
    input  pipe_pkg::fwd_sel_t fwd_rs1_i,
    input  pipe_pkg::fwd_sel_t fwd_rs2_i,
    input  isa_pkg::data_t     mem_fwd_i,
    input  pipe_pkg::wb_t      wb_i,
    output logic               redirect_o,
    output isa_pkg::data_t     target_o,
    output pipe_pkg::ex_mem_t  ex_mem_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    data_t op_a;
    data_t op_b_reg;
    data_t op_b;
    data_t alu_out;
    logic  taken;

    function automatic data_t fwd_mux(fwd_sel_t sel, data_t reg_val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_i.data;
            default: return reg_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_rs1_i, id_ex_i.rs1_data);
    assign op_b_reg = fwd_mux(fwd_rs2_i, id_ex_i.rs2_data);
    assign op_b     = id_ex_i.alu_src_imm ? id_ex_i.imm : op_b_reg;

    // ------------------------------
    // ALU.
    // ------------------------------
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // BNE inverts the equality test.
    assign taken      = id_ex_i.branch && ((op_a == op_b_reg) != id_ex_i.branch_ne);
    assign redirect_o = taken || id_ex_i.jump;
    assign target_o   = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.alu_res    <= alu_out;
            ex_mem_o.store_data <= op_b_reg;
            ex_mem_o.link       <= id_ex_i.jump ? id_ex_i.pc + 64'd4 : alu_out;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
            ex_mem_o.mem_we     <= id_ex_i.mem_we;
            ex_mem_o.mem_read   <= id_ex_i.mem_read;
        end
    end

endmodule

/* decode/decode_stage.sv */
/*
 * Decoder, immediate generation and register file.
 * Unsupported words, invalid slots and x0 destinations give no write.
 * The register file has no reset; a write from write-back is seen by
 * a read in the same cycle.
 */
`timescale 1ns/1ps

module decode_stage (
    input  logic               i_clk,
    input  logic               i_arst,
    input  pipe_pkg::if_id_t   if_id_i,
    input  pipe_pkg::wb_t      wb_i,
    input  logic               stall_i,
    input  logic               flush_i,
    output isa_pkg::reg_addr_t rs1_addr_o,
    output isa_pkg::reg_addr_t rs2_addr_o,
    output pipe_pkg::id_ex_t   id_ex_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    data_t      rf [1:31];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    data_t      imm_i;
    data_t      imm_s;
    data_t      imm_b;
    data_t      imm_j;
    logic       supported;
    id_ex_t     id_ex_d;

    assign opcode     = if_id_i.instr[6:0];
    assign rd         = if_id_i.instr[11:7];
    assign funct3     = if_id_i.instr[14:12];
    assign rs1_addr_o = if_id_i.instr[19:15];
    assign rs2_addr_o = if_id_i.instr[24:20];
    assign funct7     = if_id_i.instr[31:25];

    // ------------------------------
    // Immediates.
    // ------------------------------
    assign imm_i = {{52{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
    assign imm_s = {{52{if_id_i.instr[31]}}, if_id_i.instr[31:25], if_id_i.instr[11:7]};
    assign imm_b = {{51{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[7],
                    if_id_i.instr[30:25], if_id_i.instr[11:8], 1'b0};
    assign imm_j = {{43{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[19:12],
                    if_id_i.instr[20], if_id_i.instr[30:21], 1'b0};

    // Read with x0 and write-back bypass.
    function automatic data_t rf_read(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_i.reg_we && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return rf[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (wb_i.reg_we && wb_i.rd != '0) begin
            rf[wb_i.rd] <= wb_i.data;
        end
    end

    // ------------------------------
    // Control decode.
    // ------------------------------
    always_comb begin
        id_ex_d          = '0;
        supported        = 1'b1;
        id_ex_d.alu_op   = ALU_ADD;
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.rs1_data = rf_read(rs1_addr_o);
        id_ex_d.rs2_data = rf_read(rs2_addr_o);
        id_ex_d.rs1_addr = rs1_addr_o;
        id_ex_d.rs2_addr = rs2_addr_o;
        id_ex_d.rd       = rd;
        case (opcode)
            OP_REG: begin
                id_ex_d.reg_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: id_ex_d.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  id_ex_d.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}:     id_ex_d.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}:     id_ex_d.alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      id_ex_d.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     id_ex_d.alu_op = ALU_AND;
                    default:               supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                supported           = (funct3 == F3_ADD_SUB);
                id_ex_d.reg_we      = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.imm         = imm_i;
            end
            OP_LOAD: begin
                supported           = (funct3 == F3_DW);
                id_ex_d.reg_we      = 1'b1;
                id_ex_d.mem_read    = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.imm         = imm_i;
            end
            OP_STORE: begin
                supported           = (funct3 == F3_DW);
                id_ex_d.mem_we      = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.imm         = imm_s;
            end
            OP_BRANCH: begin
                supported         = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                id_ex_d.branch    = 1'b1;
                id_ex_d.branch_ne = (funct3 == F3_BNE);
                id_ex_d.imm       = imm_b;
            end
            OP_JAL: begin
                id_ex_d.jump   = 1'b1;
                id_ex_d.reg_we = 1'b1;
                id_ex_d.imm    = imm_j;
            end
            default: supported = 1'b0;
        endcase
        id_ex_d.reg_we = id_ex_d.reg_we && (rd != '0);
        if (!supported || !if_id_i.valid) begin
            id_ex_d = '0;
        end
    end

    // Flush wins, so a load-use stall sends a bubble to execute.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            id_ex_o <= '0;
        end else if (flush_i) begin
            id_ex_o <= '0;
        end else if (!stall_i) begin
            id_ex_o <= id_ex_d;
        end
    end

    // Write-back never targets x0.
    a_x0_zero : assert property (@(posedge i_clk) disable iff (i_arst)
        wb_i.reg_we |-> wb_i.rd != '0);

endmodule

/* fetch/fetch_stage.sv */
/*
 * PC and word-wide instruction memory. The write port takes a word
 * index, not a byte address. The PC is held at 0 while run_i is low.
 * A redirect wins over a stall.
 */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic             i_clk,
    input  logic             i_arst,
    input  logic             run_i,
    input  logic             imem_we_i,
    input  isa_pkg::data_t   imem_addr_i,
    input  isa_pkg::instr_t  imem_data_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  logic             redirect_i,
    input  isa_pkg::data_t   target_i,
    output pipe_pkg::if_id_t if_id_o
);

    import isa_pkg::*;

    localparam int IA_W = $clog2(IMEM_DEPTH);

    instr_t imem [IMEM_DEPTH];
    data_t  pc;

    always_ff @(posedge i_clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i[IA_W-1:0]] <= imem_data_i;
        end
    end

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            pc      <= '0;
            if_id_o <= '0;
        end else if (!run_i) begin
            pc            <= '0;
            if_id_o.valid <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc <= target_i;
            end else if (!stall_i) begin
                pc <= pc + 64'd4;
            end
            // Flush drops the word in flight to decode.
            if (flush_i) begin
                if_id_o.valid <= 1'b0;
            end else if (!stall_i) begin
                if_id_o.pc    <= pc;
                if_id_o.instr <= imem[pc[IA_W+1:2]];
                if_id_o.valid <= 1'b1;
            end
        end
    end

    a_imem_addr : assert property (@(posedge i_clk) disable iff (i_arst)
        imem_we_i |-> imem_addr_i < data_t'(IMEM_DEPTH));

endmodule

/* common/pipe_pkg.sv */
/*
 * Stage register contents of the five-stage pipeline.
 * A bubble is an all-zero record: every write enable is low.
 */
package pipe_pkg;

    import isa_pkg::*;

    // Fetch to decode.
    typedef struct packed {
        data_t  pc;
        instr_t instr;
        logic   valid;
    } if_id_t;

    // Decode to execute.
    typedef struct packed {
        alu_op_t   alu_op;
        logic      alu_src_imm;
        logic      reg_we;
        logic      mem_we;
        logic      mem_read;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        data_t     pc;
        data_t     rs1_data;
        data_t     rs2_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd;
        data_t     imm;
    } id_ex_t;

    // Execute to memory.
    typedef struct packed {
        data_t     alu_res;      // Also the data address.
        data_t     store_data;
        data_t     link;         // Value for rd, pc+4 on JAL.
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_we;
        logic      mem_read;
    } ex_mem_t;

    // Register write from write-back.
    typedef struct packed {
        logic      reg_we;
        reg_addr_t rd;
        data_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

/* common/isa_pkg.sv */
/*
 * RV64I subset used by the core. Only the fields of ADD, SUB, AND, OR,
 * XOR, SLT, ADDI, LD, SD, BEQ, BNE and JAL are listed here.
 * Any other encoding is turned into a bubble by the decoder.
 */
package isa_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;

    // ------------------------------
    // Major opcodes.
    // ------------------------------
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Funct3 and funct7 fields.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_DW      = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

endpackage
